// File: rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010; // LW and SW.
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        alu_op_e    alu_op;
        br_cond_e   br_cond;
        logic       is_lui;
        logic       is_auipc;
        logic       is_jal;
        logic       is_jalr;
        logic       is_branch;
        logic       is_load;
        logic       is_store;
        logic       op2_is_reg;
        logic       op1_is_pc;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

endpackage

// File: rv_bus_master.sv
`timescale 1ns/10ps

module rv_bus_master
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_req_valid,
    input  bus_req_t i_req,
    input  logic     i_ack,
    input  logic     i_stall,
    input  word_t    i_data,
    output logic     o_cyc,
    output logic     o_stb,
    output logic     o_we,
    output word_t    o_addr,
    output word_t    o_data,
    output logic     o_done,
    output word_t    o_rdata
);

    logic ack_ok;

    assign ack_ok = o_cyc && i_ack && !i_stall; // A stalled ack does not end the access.

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc  <= 1'b0;
            o_stb  <= 1'b0;
            o_we   <= 1'b0;
            o_addr <= '0;
            o_data <= '0;
            o_done <= 1'b0;
        end else begin
            o_stb  <= 1'b0; // Strobe lasts a single cycle.
            o_done <= ack_ok;
            if (ack_ok) begin
                o_cyc  <= 1'b0;
                o_we   <= 1'b0;
                o_addr <= '0;
                o_data <= '0;
            end else if (i_req_valid && !o_cyc) begin
                o_cyc  <= 1'b1;
                o_stb  <= 1'b1;
                o_we   <= i_req.we;
                o_addr <= i_req.addr;
                o_data <= i_req.we ? i_req.wdata : '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (ack_ok) begin
            o_rdata <= i_data;
        end
    end

endmodule

// File: rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder
    import rv_pkg::*;
(
    input  word_t    i_instr,
    output decoded_t o_dec,
    output word_t    o_imm
);

    instr_t     ins;
    logic [2:0] f3;
    logic       alt;
    logic       alu_ok;
    alu_op_e    alu_op;

    assign ins = i_instr;
    assign f3  = ins.r.funct3;
    assign alt = (ins.r.funct7 == F7_ALT);

    // Bit 30 picks SUB only on register ops, on immediates it is part of the constant.
    always_comb begin
        case (f3)
            F3_ADD:  alu_op = (alt && ins.r.opcode == OP_REG) ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_op = ALU_SLL;
            F3_SLT:  alu_op = ALU_SLT;
            F3_SLTU: alu_op = ALU_SLTU;
            F3_XOR:  alu_op = ALU_XOR;
            F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        alu_ok = 1'b1;
        if (ins.r.opcode == OP_REG) begin
            alu_ok = (ins.r.funct7 == 7'd0) || (alt && (f3 == F3_ADD || f3 == F3_SR));
        end else if (f3 == F3_SLL) begin
            alu_ok = (ins.r.funct7 == 7'd0);
        end else if (f3 == F3_SR) begin
            alu_ok = (ins.r.funct7 == 7'd0) || alt;
        end
    end

    always_comb begin
        o_dec         = '0; // Unknown words fall through as no-ops writing x0.
        o_dec.alu_op  = ALU_ADD;
        o_dec.br_cond = BR_EQ;
        o_imm         = {{20{ins.i.imm[11]}}, ins.i.imm};
        case (ins.r.opcode)
            OP_LUI, OP_AUIPC: begin
                o_dec.rd        = ins.u.rd;
                o_dec.is_lui    = (ins.u.opcode == OP_LUI);
                o_dec.is_auipc  = (ins.u.opcode == OP_AUIPC);
                o_dec.op1_is_pc = (ins.u.opcode == OP_AUIPC);
                o_imm           = {ins.u.imm, 12'b0};
            end
            OP_JAL: begin
                o_dec.rd        = ins.j.rd;
                o_dec.is_jal    = 1'b1;
                o_dec.op1_is_pc = 1'b1;
                o_imm = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                         ins.j.imm10_1, 1'b0};
            end
            OP_JALR: begin
                if (ins.i.funct3 == 3'b000) begin
                    o_dec.rd      = ins.i.rd;
                    o_dec.rs1     = ins.i.rs1;
                    o_dec.is_jalr = 1'b1;
                end
            end
            OP_BRANCH: begin
                if (f3[2:1] != 2'b01) begin
                    o_dec.rs1       = ins.b.rs1;
                    o_dec.rs2       = ins.b.rs2;
                    o_dec.is_branch = 1'b1;
                    o_dec.op1_is_pc = 1'b1; // The ALU forms the target, the compare is separate.
                    o_imm = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                             ins.b.imm4_1, 1'b0};
                    case (f3)
                        F3_BEQ:  o_dec.br_cond = BR_EQ;
                        F3_BNE:  o_dec.br_cond = BR_NE;
                        F3_BLT:  o_dec.br_cond = BR_LT;
                        F3_BGE:  o_dec.br_cond = BR_GE;
                        F3_BLTU: o_dec.br_cond = BR_LTU;
                        default: o_dec.br_cond = BR_GEU;
                    endcase
                end
            end
            OP_IMM: begin
                if (alu_ok) begin
                    o_dec.rd     = ins.i.rd;
                    o_dec.rs1    = ins.i.rs1;
                    o_dec.alu_op = alu_op;
                end
            end
            OP_REG: begin
                if (alu_ok) begin
                    o_dec.rd         = ins.r.rd;
                    o_dec.rs1        = ins.r.rs1;
                    o_dec.rs2        = ins.r.rs2;
                    o_dec.op2_is_reg = 1'b1;
                    o_dec.alu_op     = alu_op;
                end
            end
            OP_LOAD: begin
                if (f3 == F3_WORD) begin
                    o_dec.rd      = ins.i.rd;
                    o_dec.rs1     = ins.i.rs1;
                    o_dec.is_load = 1'b1;
                end
            end
            OP_STORE: begin
                if (f3 == F3_WORD) begin
                    o_dec.rs1      = ins.s.rs1;
                    o_dec.rs2      = ins.s.rs2;
                    o_dec.is_store = 1'b1;
                    o_imm = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_we,
    input  logic [4:0] i_waddr,
    input  word_t      i_wdata,
    input  logic [4:0] i_raddr1,
    input  logic [4:0] i_raddr2,
    output word_t      o_rdata1,
    output word_t      o_rdata2
);

    word_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != 5'd0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_raddr1 == 5'd0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == 5'd0) ? '0 : regs[i_raddr2];

endmodule

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_en,
    input  alu_op_e  i_op,
    input  br_cond_e i_br,
    input  word_t    i_a,
    input  word_t    i_b,
    input  word_t    i_ra,
    input  word_t    i_rb,
    output word_t    o_result,
    output logic     o_taken
);

    logic [4:0] shamt;
    word_t      result;
    logic       taken;

    assign shamt = i_b[4:0]; // Immediate shifts carry shamt in the low bits of the immediate.

    always_comb begin
        case (i_op)
            ALU_SUB:  result = i_a - i_b;
            ALU_SLT:  result = {31'b0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: result = {31'b0, i_a < i_b};
            ALU_XOR:  result = i_a ^ i_b;
            ALU_OR:   result = i_a | i_b;
            ALU_AND:  result = i_a & i_b;
            ALU_SLL:  result = i_a << shamt;
            ALU_SRL:  result = i_a >> shamt;
            ALU_SRA:  result = word_t'($signed(i_a) >>> shamt);
            default:  result = i_a + i_b;
        endcase
        case (i_br)
            BR_EQ:   taken = (i_ra == i_rb);
            BR_NE:   taken = (i_ra != i_rb);
            BR_LT:   taken = ($signed(i_ra) < $signed(i_rb));
            BR_GE:   taken = ($signed(i_ra) >= $signed(i_rb));
            BR_LTU:  taken = (i_ra < i_rb);
            default: taken = (i_ra >= i_rb);
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_result <= result;
            o_taken  <= taken;
        end
    end

endmodule

// File: rv_stage_ctrl.sv
`timescale 1ns/10ps

module rv_stage_ctrl
    import rv_pkg::*;
#(
    parameter word_t PC_START = 32'h2040_0000
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_done,
    input  word_t      i_rdata,
    input  decoded_t   i_dec,
    input  word_t      i_imm,
    input  word_t      i_rs1_val,
    input  word_t      i_rs2_val,
    input  word_t      i_alu_result,
    input  logic       i_taken,
    output word_t      o_instr,
    output logic       o_req_valid,
    output bus_req_t   o_req,
    output logic       o_alu_en,
    output word_t      o_alu_a,
    output word_t      o_alu_b,
    output logic       o_rf_we,
    output logic [4:0] o_rf_waddr,
    output word_t      o_rf_wdata
);

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_PREPARE, ST_EXECUTE, ST_ACCESS, ST_WRITEBACK
    } stage_e;

    stage_e   stage;
    logic     busy;
    word_t    pc;
    word_t    next_pc;
    decoded_t dec_q;
    word_t    imm_q;

    assign o_req_valid = ((stage == ST_FETCH) || (stage == ST_ACCESS)) && !busy;
    assign o_req.addr  = (stage == ST_ACCESS) ? i_alu_result : next_pc;
    assign o_req.wdata = i_rs2_val;
    assign o_req.we    = (stage == ST_ACCESS) && dec_q.is_store;
    assign o_alu_en    = (stage == ST_EXECUTE);
    assign o_rf_we     = (stage == ST_WRITEBACK); // Non-writers decode to rd = x0.
    assign o_rf_waddr  = dec_q.rd;

    always_comb begin
        if (dec_q.is_lui) begin
            o_rf_wdata = imm_q;
        end else if (dec_q.is_jal || dec_q.is_jalr) begin
            o_rf_wdata = next_pc; // Link address, already pc + 4.
        end else if (dec_q.is_load) begin
            o_rf_wdata = i_rdata;
        end else begin
            o_rf_wdata = i_alu_result;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage   <= ST_FETCH;
            busy    <= 1'b0;
            pc      <= PC_START;
            next_pc <= PC_START;
        end else begin
            case (stage)
                ST_FETCH: begin
                    if (o_req_valid) begin
                        busy    <= 1'b1;
                        pc      <= next_pc;
                        next_pc <= next_pc + 32'd4;
                    end
                    if (i_done) begin
                        busy  <= 1'b0;
                        stage <= ST_DECODE;
                    end
                end
                ST_DECODE:  stage <= ST_PREPARE;
                ST_PREPARE: stage <= ST_EXECUTE;
                ST_EXECUTE: stage <= (dec_q.is_load || dec_q.is_store) ? ST_ACCESS : ST_WRITEBACK;
                ST_ACCESS: begin
                    if (o_req_valid) begin
                        busy <= 1'b1;
                    end
                    if (i_done) begin
                        busy  <= 1'b0;
                        stage <= dec_q.is_store ? ST_FETCH : ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    if ((dec_q.is_branch && i_taken) || dec_q.is_jal) begin
                        next_pc <= i_alu_result;
                    end else if (dec_q.is_jalr) begin
                        next_pc <= {i_alu_result[31:1], 1'b0};
                    end
                    stage <= ST_FETCH;
                end
                default: stage <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if ((stage == ST_FETCH) && i_done) begin
            o_instr <= i_rdata;
        end
        if (stage == ST_DECODE) begin
            dec_q <= i_dec;
            imm_q <= i_imm;
        end
        if (stage == ST_PREPARE) begin
            o_alu_a <= dec_q.op1_is_pc ? pc : i_rs1_val;
            o_alu_b <= dec_q.op2_is_reg ? i_rs2_val : imm_q; // Immediate also carries shamt.
        end
    end

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core
    import rv_pkg::*;
#(
    parameter word_t PC_START = 32'h2040_0000
) (
    input  logic  i_clk,
    input  logic  i_rst,
    output logic  o_cyc,
    output logic  o_stb,
    output logic  o_we,
    output word_t o_addr,
    output word_t o_data,
    input  logic  i_ack,
    input  logic  i_stall,
    input  word_t i_data
);

    logic       req_valid;
    bus_req_t   req;
    logic       done;
    word_t      rdata;
    word_t      instr;
    decoded_t   dec;
    word_t      imm;
    word_t      rs1_val;
    word_t      rs2_val;
    logic       alu_en;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic       taken;
    logic       rf_we;
    logic [4:0] rf_waddr;
    word_t      rf_wdata;

    rv_bus_master i_bus_master (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .i_ack       (i_ack),
        .i_stall     (i_stall),
        .i_data      (i_data),
        .o_cyc       (o_cyc),
        .o_stb       (o_stb),
        .o_we        (o_we),
        .o_addr      (o_addr),
        .o_data      (o_data),
        .o_done      (done),
        .o_rdata     (rdata)
    );

    rv_decoder i_decoder (
        .i_instr (instr),
        .o_dec   (dec),
        .o_imm   (imm)
    );

    // Register addresses come straight from the decoder, the instruction word is held.
    rv_regfile i_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (rf_we),
        .i_waddr  (rf_waddr),
        .i_wdata  (rf_wdata),
        .i_raddr1 (dec.rs1),
        .i_raddr2 (dec.rs2),
        .o_rdata1 (rs1_val),
        .o_rdata2 (rs2_val)
    );

    rv_alu i_alu (
        .i_clk    (i_clk),
        .i_en     (alu_en),
        .i_op     (dec.alu_op),
        .i_br     (dec.br_cond),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_ra     (rs1_val),
        .i_rb     (rs2_val),
        .o_result (alu_result),
        .o_taken  (taken)
    );

    rv_stage_ctrl #(
        .PC_START (PC_START)
    ) i_stage_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_done       (done),
        .i_rdata      (rdata),
        .i_dec        (dec),
        .i_imm        (imm),
        .i_rs1_val    (rs1_val),
        .i_rs2_val    (rs2_val),
        .i_alu_result (alu_result),
        .i_taken      (taken),
        .o_instr      (instr),
        .o_req_valid  (req_valid),
        .o_req        (req),
        .o_alu_en     (alu_en),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .o_rf_we      (rf_we),
        .o_rf_waddr   (rf_waddr),
        .o_rf_wdata   (rf_wdata)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk; // 10 ns period.
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// File: rv_core_props.sv
`timescale 1ns/10ps

module rv_core_props
    import rv_pkg::*;
(
    input logic  i_clk,
    input logic  i_rst,
    input logic  i_cyc,
    input logic  i_stb,
    input logic  i_we,
    input word_t i_addr
);

    int unsigned fail_count = 0;

    stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst) i_stb |-> i_cyc)
        else begin
            $error("o_stb is high while o_cyc is low");
            fail_count++;
        end

    stb_single: assert property (@(posedge i_clk) disable iff (i_rst) i_stb |=> !i_stb)
        else begin
            $error("o_stb is high for two cycles in a row");
            fail_count++;
        end

    // After the strobe cycle the access is held until the bus master drops o_cyc.
    held_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_cyc && !i_stb) |-> ($stable(i_addr) && $stable(i_we)))
        else begin
            $error("o_addr or o_we changed while o_cyc was held");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_cyc)
        else begin
            $error("o_cyc is high during reset or in the cycle after it");
            fail_count++;
        end

endmodule

bind rv_bus_master rv_core_props i_rv_core_props (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_cyc  (o_cyc),
    .i_stb  (o_stb),
    .i_we   (o_we),
    .i_addr (o_addr)
);

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core
    import rv_pkg::*;
#(
    parameter word_t PC_START  = 32'h2040_0000,
    parameter int    MEM_WORDS = 1024,
    parameter int    SEED      = 69
) ();

    logic     clk;
    logic     rst;
    logic     cyc;
    logic     stb;
    logic     we;
    word_t    addr;
    word_t    wdata;
    logic     ack   = 1'b0;
    logic     stall = 1'b0;
    word_t    rdata = '0;
    word_t    mem [MEM_WORDS];
    bus_req_t exp_q [$];
    int       prog_len;
    int       res_off;
    int       wait_left;
    logic     stall_used;

    tb_clk_gen #(
        .RESET_CYCLES (8)
    ) i_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    rv_core #(
        .PC_START (PC_START)
    ) i_rv_core (
        .i_clk   (clk),
        .i_rst   (rst),
        .o_cyc   (cyc),
        .o_stb   (stb),
        .o_we    (we),
        .o_addr  (addr),
        .o_data  (wdata),
        .i_ack   (ack),
        .i_stall (stall),
        .i_data  (rdata)
    );

    function automatic int mem_index(word_t a);
        return int'(((a - PC_START) >> 2) & (MEM_WORDS - 1));
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                    logic [4:0] rs1, logic [4:0] rs2);
        instr_t w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP_REG};
        return w;
    endfunction

    function automatic word_t enc_i(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                    logic [4:0] rs1, logic [11:0] imm);
        instr_t w;
        w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic word_t enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        instr_t w;
        w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: F3_WORD, imm_lo: imm[4:0],
                opcode: OP_STORE};
        return w;
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                    logic [12:0] off);
        instr_t w;
        w.b = '{imm12: off[12], imm10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
                imm4_1: off[4:1], imm11: off[11], opcode: OP_BRANCH};
        return w;
    endfunction

    function automatic word_t enc_u(opcode_e op, logic [4:0] rd, logic [19:0] imm);
        instr_t w;
        w.u = '{imm: imm, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic word_t enc_j(logic [4:0] rd, logic [20:0] off);
        instr_t w;
        w.j = '{imm20: off[20], imm10_1: off[10:1], imm11: off[11], imm19_12: off[19:12],
                rd: rd, opcode: OP_JAL};
        return w;
    endfunction

    task automatic emit(word_t w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_const(logic [4:0] rd, word_t value);
        word_t hi;
        hi = value + 32'h800; // Compensates the sign of the ADDI immediate.
        emit(enc_u(OP_LUI, rd, hi[31:12]));
        emit(enc_i(OP_IMM, F3_ADD, rd, rd, value[11:0]));
    endtask

    task automatic store_result(logic [4:0] rs);
        emit(enc_s(rs, 5'd10, res_off[11:0]));
        res_off += 4;
    endtask

    task automatic build_program();
        logic [4:0]  src_a [3];
        logic [4:0]  src_b [3];
        logic [4:0]  br_a [3];
        logic [4:0]  br_b [3];
        logic [2:0]  br_f3 [6];
        logic [4:0]  sh;
        logic [11:0] imm;
        src_a = '{5'd1, 5'd2, 5'd4};
        src_b = '{5'd2, 5'd4, 5'd5};
        br_a  = '{5'd1, 5'd1, 5'd2};
        br_b  = '{5'd3, 5'd2, 5'd1};
        br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        mem      = '{default: '0};
        prog_len = 0;
        res_off  = 0;
        load_const(5'd10, PC_START + 32'h800); // x10 points at the result area.
        load_const(5'd1, $urandom & 32'h7fff_ffff);
        load_const(5'd2, $urandom | 32'h8000_0000);
        load_const(5'd4, $urandom);
        load_const(5'd5, $urandom);
        emit(enc_r(7'd0, F3_ADD, 5'd3, 5'd1, 5'd0));
        for (int p = 0; p < 3; p++) begin
            for (int f = 0; f < 8; f++) begin
                emit(enc_r(7'd0, f[2:0], 5'd20, src_a[p], src_b[p]));
                store_result(5'd20);
            end
            emit(enc_r(F7_ALT, F3_ADD, 5'd20, src_a[p], src_b[p]));
            store_result(5'd20);
            emit(enc_r(F7_ALT, F3_SR, 5'd20, src_a[p], src_b[p]));
            store_result(5'd20);
            for (int f = 0; f < 8; f++) begin
                sh  = 5'($urandom_range(31, 0));
                imm = 12'($urandom);
                if (f == F3_SLL || f == F3_SR) begin
                    imm = {7'd0, sh};
                end
                emit(enc_i(OP_IMM, f[2:0], 5'd20, src_a[p], imm));
                store_result(5'd20);
            end
            emit(enc_i(OP_IMM, F3_SR, 5'd20, src_a[p], {F7_ALT, sh}));
            store_result(5'd20);
        end
        for (int k = 0; k < 2; k++) begin
            emit(enc_u(OP_LUI, 5'd21, 20'($urandom)));
            store_result(5'd21);
            emit(enc_u(OP_AUIPC, 5'd21, 20'($urandom)));
            store_result(5'd21);
        end
        // Every condition meets an equal, a signed-less and a signed-greater pair.
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_b(br_f3[c], br_a[p], br_b[p], 13'd8));
                store_result(5'd1); // Marker that a taken branch skips.
            end
        end
        emit(enc_j(5'd21, 21'd8));
        store_result(5'd1);
        store_result(5'd21);
        emit(enc_u(OP_AUIPC, 5'd22, 20'd0));
        emit(enc_i(OP_JALR, 3'b000, 5'd23, 5'd22, 12'd13)); // Odd target whose bit 0 is dropped.
        store_result(5'd1);
        store_result(5'd23);
        emit(enc_s(5'd2, 5'd10, 12'h7f0));
        emit(enc_i(OP_LOAD, F3_WORD, 5'd24, 5'd10, 12'h7f0));
        store_result(5'd24);
        emit(enc_i(OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd5));
        store_result(5'd0);
        emit(enc_j(5'd0, 21'd0)); // Jump to itself ends the program.
    endtask

    function automatic word_t isa_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return (sa < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SR: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void expect_access(word_t a, word_t d, logic w);
        bus_req_t acc;
        acc.addr  = a;
        acc.wdata = d;
        acc.we    = w;
        exp_q.push_back(acc);
    endfunction

    // Instruction-set model that lists every bus access the program should make.
    function automatic void model_program();
        word_t  m [MEM_WORDS];
        word_t  x [32];
        word_t  pc;
        word_t  nxt;
        word_t  a;
        word_t  b;
        word_t  ea;
        word_t  res;
        instr_t w;
        logic   wr;
        logic   taken;
        m  = mem;
        x  = '{default: '0};
        pc = PC_START;
        for (int step = 0; step < MEM_WORDS; step++) begin
            expect_access(pc, '0, 1'b0);
            w = m[mem_index(pc)];
            if (w == enc_j(5'd0, 21'd0)) begin
                return;
            end
            a     = x[w.r.rs1];
            b     = x[w.r.rs2];
            nxt   = pc + 32'd4;
            wr    = 1'b1;
            res   = '0;
            taken = 1'b0;
            case (w.r.opcode)
                OP_LUI:   res = {w.u.imm, 12'd0};
                OP_AUIPC: res = pc + {w.u.imm, 12'd0};
                OP_JAL: begin
                    res = nxt;
                    nxt = pc + {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11,
                                w.j.imm10_1, 1'b0};
                end
                OP_JALR: begin
                    res = nxt;
                    nxt = (a + {{20{w.i.imm[11]}}, w.i.imm}) & ~32'd1;
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    case (w.b.funct3)
                        F3_BEQ:  taken = (a == b);
                        F3_BNE:  taken = (a != b);
                        F3_BLT:  taken = ($signed(a) < $signed(b));
                        F3_BGE:  taken = ($signed(a) >= $signed(b));
                        F3_BLTU: taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    if (taken) begin
                        nxt = pc + {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5,
                                    w.b.imm4_1, 1'b0};
                    end
                end
                OP_IMM: res = isa_alu(w.i.funct3, (w.i.funct3 == F3_SR) && w.r.funct7[5], a,
                                      {{20{w.i.imm[11]}}, w.i.imm});
                OP_REG: res = isa_alu(w.r.funct3, w.r.funct7[5], a, b);
                OP_LOAD: begin
                    ea = a + {{20{w.i.imm[11]}}, w.i.imm};
                    expect_access(ea, '0, 1'b0);
                    res = m[mem_index(ea)];
                end
                OP_STORE: begin
                    wr = 1'b0;
                    ea = a + {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
                    expect_access(ea, b, 1'b1);
                    m[mem_index(ea)] = b;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w.r.rd != 5'd0) begin
                x[w.r.rd] = res;
            end
            pc = nxt;
        end
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_field(string name, word_t got, word_t want);
        assert (got === want) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    // Memory responder with random ack latency and an occasional stalled ack.
    always @(negedge clk) begin
        ack   <= 1'b0;
        stall <= 1'b0;
        rdata <= '0;
        if (!rst && cyc) begin
            if (stb) begin
                wait_left  = $urandom_range(3, 0);
                stall_used = 1'b0;
                if (we) begin
                    mem[mem_index(addr)] = wdata;
                end
            end
            if (wait_left != 0) begin
                wait_left--;
            end else begin
                ack <= 1'b1;
                if (!stall_used && $urandom_range(3, 0) == 0) begin
                    stall      <= 1'b1;
                    stall_used = 1'b1;
                    rdata      <= we ? '0 : ~mem[mem_index(addr)]; // Garbage under a stall.
                end else begin
                    rdata <= we ? '0 : mem[mem_index(addr)];
                end
            end
        end
    end

    always @(negedge clk) begin
        bus_req_t want;
        if (!rst) begin
            assert (i_rv_core.i_bus_master.i_rv_core_props.fail_count == 0) else begin
                $display("A bus protocol assertion failed before %0t.", $time);
                abort_run();
            end
        end
        if (!rst && stb) begin
            assert (exp_q.size() != 0) else begin
                $display("Bus access to %h came after the program should have ended.", addr);
                abort_run();
            end
            want = exp_q.pop_front();
            check_field("o_we", word_t'(we), word_t'(want.we));
            check_field("o_addr", addr, want.addr);
            check_field("o_data", wdata, want.wdata);
        end
    end

    initial begin
        int limit;
        int cycles;
        void'($urandom(SEED));
        build_program();
        model_program();
        limit  = prog_len * 20 + 50; // A load with two slow stalled accesses needs 18 cycles.
        cycles = 0;
        @(negedge rst);
        while (exp_q.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() == 0 && i_rv_core.i_bus_master.i_rv_core_props.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with %0d bus accesses still expected.",
                     cycles, exp_q.size());
            abort_run();
        end
    end

endmodule

// File: src.f
rv_pkg.sv
rv_bus_master.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_stage_ctrl.sv
rv_core.sv
tb_clk_gen.sv
rv_core_props.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_bus_master.sv
  - rv_decoder.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_stage_ctrl.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - rv_core_props.sv
      - tb_rv_core.sv
